// ==== hdl/pipe_pkg.sv ====
// Shared ALU opcode and operand select encodings; default widths only, modules may override
`default_nettype none

package pipe_pkg;

	//////////////////////////////////////////////////
	// Default widths
	//////////////////////////////////////////////////

	// Operand and result width, 16 also supported
	parameter int DATA_WIDTH = 32;

	// Register address width, 32 registers at 5 bits
	parameter int REG_ADDR_WIDTH = 5;

	//////////////////////////////////////////////////
	// ALU operations
	//////////////////////////////////////////////////

	// Decoded ALU operation carried with each instruction
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		// Shift amount taken from the low bits of operand B
		ALU_SLL    = 3'd5,
		ALU_SRL    = 3'd6,
		// Result is operand B unchanged
		ALU_PASS_B = 3'd7
	} alu_op_e;

	//////////////////////////////////////////////////
	// Operand sources
	//////////////////////////////////////////////////

	// Where an operand register loads from
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		// Only meaningful for operand B
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} operand_sel_e;

endpackage

`default_nettype wire

// ==== hdl/reg_file.sv ====
// Two async read ports, one write port; reads do not see a same-cycle write, forwarding covers it
`default_nettype none
`timescale 1ns/10ps

module reg_file #(
	parameter int data_width = pipe_pkg::DATA_WIDTH,
	parameter int addr_width = pipe_pkg::REG_ADDR_WIDTH
) (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	// Read addresses from decode
	input  wire logic [addr_width-1:0] ra,
	input  wire logic [addr_width-1:0] rb,
	// Write port fed by writeback
	input  wire logic [addr_width-1:0] rd,
	input  wire logic                  wen,
	input  wire logic [data_width-1:0] wdata,
	// Read data
	output logic      [data_width-1:0] data_a,
	output logic      [data_width-1:0] data_b
);

	// One entry per register address
	localparam int depth = 1 << addr_width;

	logic [data_width-1:0] regs [depth];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	// Reset clears the whole array
	// Register 0 is never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < depth; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (rd != '0)) begin
			regs[rd] <= wdata;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Combinational from address to data
	// Register 0 reads as zero
	assign data_a = (ra == '0) ? '0 : regs[ra];
	assign data_b = (rb == '0) ? '0 : regs[rb];

endmodule

`default_nettype wire

// ==== hdl/forward_ctrl.sv ====
// Hazard check against execute and writeback only; callers must keep ex_wen and wb_wen low for bubbles
`default_nettype none
`timescale 1ns/10ps

module forward_ctrl #(
	parameter int addr_width = pipe_pkg::REG_ADDR_WIDTH
) (
	// Source registers of the instruction in decode
	input  wire logic [addr_width-1:0] ra,
	input  wire logic [addr_width-1:0] rb,
	input  wire logic                  use_imm,
	// Producer now in execute
	input  wire logic [addr_width-1:0] ex_rd,
	input  wire logic                  ex_wen,
	// Producer now in writeback
	input  wire logic [addr_width-1:0] wb_rd,
	input  wire logic                  wb_wen,
	// Operand source selects
	output pipe_pkg::operand_sel_e     sel_a,
	output pipe_pkg::operand_sel_e     sel_b
);

	// Pick the newest producer of a source register
	// Execute holds the younger result, so it wins over writeback
	function automatic pipe_pkg::operand_sel_e pick_source(
		input logic [addr_width-1:0] src
	);
		pipe_pkg::operand_sel_e sel;
		sel = pipe_pkg::SEL_RF;
		// Register 0 is constant, never forwarded
		if (src != '0) begin
			if (ex_wen && (ex_rd == src)) begin
				sel = pipe_pkg::SEL_EX_FORW;
			end else if (wb_wen && (wb_rd == src)) begin
				sel = pipe_pkg::SEL_WB_FORW;
			end
		end
		return sel;
	endfunction

	//////////////////////////////////////////////////
	// Select generation
	//////////////////////////////////////////////////

	// Operand A always comes from a register
	always_comb begin
		sel_a = pick_source(ra);
	end

	// Immediate overrides any hazard on B
	always_comb begin
		if (use_imm) begin
			sel_b = pipe_pkg::SEL_IMM;
		end else begin
			sel_b = pick_source(rb);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/operand_muxes.sv ====
// Operand registers for execute; a decode freeze inserts a bubble, operands are then held stable
`default_nettype none
`timescale 1ns/10ps

module operand_muxes #(
	parameter int data_width = pipe_pkg::DATA_WIDTH
) (
	input  wire logic                   clk,
	input  wire logic                   arst_n,
	// Freeze pair, execute side and decode side
	input  wire logic                   id_freeze,
	input  wire logic                   ex_freeze,
	// Candidate operand values
	input  wire logic [data_width-1:0]  rf_data_a,
	input  wire logic [data_width-1:0]  rf_data_b,
	input  wire logic [data_width-1:0]  ex_forw,
	input  wire logic [data_width-1:0]  wb_forw,
	input  wire logic [data_width-1:0]  imm,
	// Selects from forwarding control
	input  pipe_pkg::operand_sel_e      sel_a,
	input  pipe_pkg::operand_sel_e      sel_b,
	// Registered operands into execute
	output logic      [data_width-1:0]  operand_a,
	output logic      [data_width-1:0]  operand_b
);

	logic [data_width-1:0] muxed_a;
	logic [data_width-1:0] muxed_b;

	// Set once a decode freeze has been captured
	logic saved;

	//////////////////////////////////////////////////
	// Source muxes
	//////////////////////////////////////////////////

	// Operand A, no immediate path
	always_comb begin
		case (sel_a)
			pipe_pkg::SEL_EX_FORW: muxed_a = ex_forw;
			pipe_pkg::SEL_WB_FORW: muxed_a = wb_forw;
			default:               muxed_a = rf_data_a;
		endcase
	end

	// Operand B, immediate allowed
	always_comb begin
		case (sel_b)
			pipe_pkg::SEL_IMM:     muxed_b = imm;
			pipe_pkg::SEL_EX_FORW: muxed_b = ex_forw;
			pipe_pkg::SEL_WB_FORW: muxed_b = wb_forw;
			default:               muxed_b = rf_data_b;
		endcase
	end

	//////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////

	// Execute frozen: everything holds
	// First decode freeze cycle: capture once, then hold through the bubble
	// Both freezes clear: load the accepted instruction and drop the flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_a <= '0;
			operand_b <= '0;
			saved     <= 1'b0;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				if (!saved) begin
					operand_a <= muxed_a;
					operand_b <= muxed_b;
					saved     <= 1'b1;
				end
			end else begin
				operand_a <= muxed_a;
				operand_b <= muxed_b;
				saved     <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/exec_stage.sv ====
// Single-cycle ALU only; shifts use the low log2(data_width) bits of B, no overflow or flags
`default_nettype none
`timescale 1ns/10ps

module exec_stage #(
	parameter int data_width = pipe_pkg::DATA_WIDTH,
	parameter int addr_width = pipe_pkg::REG_ADDR_WIDTH
) (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	// Stall from outside, freezes both stage registers
	input  wire logic                  hold,
	// Instruction leaving decode
	input  wire logic                  id_valid,
	input  pipe_pkg::alu_op_e          op,
	input  wire logic [addr_width-1:0] rd,
	// Operands from the operand registers
	input  wire logic [data_width-1:0] operand_a,
	input  wire logic [data_width-1:0] operand_b,
	// Execute stage state, result forwarded combinationally
	output logic      [addr_width-1:0] ex_rd,
	output logic                       ex_wen,
	output logic      [data_width-1:0] ex_forw,
	// Writeback register
	output logic      [addr_width-1:0] wb_rd,
	output logic                       wb_wen,
	output logic      [data_width-1:0] wb_forw
);

	// Shift amount width
	localparam int shamt_width = $clog2(data_width);

	pipe_pkg::alu_op_e      ex_op;
	logic [data_width-1:0]  alu_result;
	logic [shamt_width-1:0] shamt;

	//////////////////////////////////////////////////
	// Execute control registers
	//////////////////////////////////////////////////

	// Stage valid bits; a bubble enters when decode has nothing
	// rd 0 never writes, so its valid is dropped here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_wen <= 1'b0;
			wb_wen <= 1'b0;
		end else if (!hold) begin
			ex_wen <= id_valid && (rd != '0);
			wb_wen <= ex_wen;
		end
	end

	// Payload, only meaningful alongside the valid bits
	always_ff @(posedge clk) begin
		if (!hold) begin
			ex_op   <= op;
			ex_rd   <= rd;
			wb_rd   <= ex_rd;
			wb_forw <= alu_result;
		end
	end

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	assign shamt = operand_b[shamt_width-1:0];

	always_comb begin
		case (ex_op)
			pipe_pkg::ALU_ADD:    alu_result = operand_a + operand_b;
			pipe_pkg::ALU_SUB:    alu_result = operand_a - operand_b;
			pipe_pkg::ALU_AND:    alu_result = operand_a & operand_b;
			pipe_pkg::ALU_OR:     alu_result = operand_a | operand_b;
			pipe_pkg::ALU_XOR:    alu_result = operand_a ^ operand_b;
			pipe_pkg::ALU_SLL:    alu_result = operand_a << shamt;
			pipe_pkg::ALU_SRL:    alu_result = operand_a >> shamt;
			pipe_pkg::ALU_PASS_B: alu_result = operand_b;
			default:              alu_result = '0;
		endcase
	end

	// Forward path for the instruction now in decode
	assign ex_forw = alu_result;

endmodule

`default_nettype wire

// ==== hdl/exec_pipe_top.sv ====
// Decoded ALU instructions only; hold stalls everything, a missing instruction inserts a bubble
`default_nettype none
`timescale 1ns/10ps

module exec_pipe_top #(
	parameter int data_width = pipe_pkg::DATA_WIDTH,
	parameter int addr_width = pipe_pkg::REG_ADDR_WIDTH
) (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	// Decoded instruction
	input  wire logic                  in_valid,
	input  pipe_pkg::alu_op_e          in_op,
	input  wire logic [addr_width-1:0] in_rd,
	input  wire logic [addr_width-1:0] in_ra,
	input  wire logic [addr_width-1:0] in_rb,
	input  wire logic [data_width-1:0] in_imm,
	input  wire logic                  in_use_imm,
	// External stall
	input  wire logic                  hold,
	output logic                       in_ready,
	// Retired results
	output logic                       wb_valid,
	output logic      [addr_width-1:0] wb_rd,
	output logic      [data_width-1:0] wb_data
);

	logic                   ex_freeze;
	logic                   id_freeze;
	logic                   rf_wen;
	logic [data_width-1:0]  rf_data_a;
	logic [data_width-1:0]  rf_data_b;
	logic [data_width-1:0]  operand_a;
	logic [data_width-1:0]  operand_b;
	logic [data_width-1:0]  ex_forw;
	logic [data_width-1:0]  wb_forw;
	logic [addr_width-1:0]  ex_rd;
	logic                   ex_wen;
	logic                   wb_wen;
	pipe_pkg::operand_sel_e sel_a;
	pipe_pkg::operand_sel_e sel_b;

	//////////////////////////////////////////////////
	// Freeze and handshake
	//////////////////////////////////////////////////

	assign ex_freeze = hold;
	assign id_freeze = !in_valid;
	assign in_ready  = !hold;

	// Register file only retires when the pipe moves
	assign rf_wen   = wb_wen && !hold;
	assign wb_valid = wb_wen;
	assign wb_data  = wb_forw;

	//////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////

	reg_file #(.data_width(data_width), .addr_width(addr_width)) reg_file_i (
		.clk(clk), .arst_n(arst_n),
		.ra(in_ra), .rb(in_rb),
		.rd(wb_rd), .wen(rf_wen), .wdata(wb_forw),
		.data_a(rf_data_a), .data_b(rf_data_b)
	);

	forward_ctrl #(.addr_width(addr_width)) forward_ctrl_i (
		.ra(in_ra), .rb(in_rb), .use_imm(in_use_imm),
		.ex_rd(ex_rd), .ex_wen(ex_wen),
		.wb_rd(wb_rd), .wb_wen(wb_wen),
		.sel_a(sel_a), .sel_b(sel_b)
	);

	operand_muxes #(.data_width(data_width)) operand_muxes_i (
		.clk(clk), .arst_n(arst_n),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .imm(in_imm),
		.sel_a(sel_a), .sel_b(sel_b),
		.operand_a(operand_a), .operand_b(operand_b)
	);

	// in_valid doubles as the accept, hold already freezes the stage
	exec_stage #(.data_width(data_width), .addr_width(addr_width)) exec_stage_i (
		.clk(clk), .arst_n(arst_n), .hold(hold),
		.id_valid(in_valid), .op(in_op), .rd(in_rd),
		.operand_a(operand_a), .operand_b(operand_b),
		.ex_rd(ex_rd), .ex_wen(ex_wen), .ex_forw(ex_forw),
		.wb_rd(wb_rd), .wb_wen(wb_wen), .wb_forw(wb_forw)
	);

endmodule

`default_nettype wire

// ==== tests/exec_pipe_properties.sv ====
// Bound to operand_muxes, reads its internal saved flag; checks are off while arst_n is low
`default_nettype none
`timescale 1ns/10ps

module exec_pipe_properties #(
	parameter int data_width = pipe_pkg::DATA_WIDTH
) (
	input wire logic                  clk,
	input wire logic                  arst_n,
	input wire logic                  id_freeze,
	input wire logic                  ex_freeze,
	input wire logic                  saved,
	input wire logic [data_width-1:0] operand_a,
	input wire logic [data_width-1:0] operand_b
);

	// Execute frozen, operand registers keep their values
	hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ex_freeze |=> ($stable(operand_a) && $stable(operand_b)))
	else $error("operand registers changed while execute was frozen");

	// Bubble already captured, no further loads
	bubble_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(id_freeze && saved) |=> ($stable(operand_a) && $stable(operand_b)))
	else $error("operand registers changed during a decode bubble");

	// First decode freeze cycle sets the flag
	saved_sets: assert property (@(posedge clk) disable iff (!arst_n)
		(id_freeze && !ex_freeze) |=> saved)
	else $error("saved flag not set after a decode freeze");

	// Both freezes released
	saved_clears: assert property (@(posedge clk) disable iff (!arst_n)
		(!id_freeze && !ex_freeze) |=> !saved)
	else $error("saved flag still set after both freezes cleared");

endmodule

bind operand_muxes exec_pipe_properties #(.data_width(data_width)) operand_props_i (
	.clk(clk), .arst_n(arst_n), .id_freeze(id_freeze), .ex_freeze(ex_freeze),
	.saved(saved), .operand_a(operand_a), .operand_b(operand_b)
);

`default_nettype wire

// ==== tests/exec_pipe_tb.sv ====
// Runs at the package default widths only and expects each result to retire once in issue order
`default_nettype none
`timescale 1ns/10ps

module exec_pipe_tb;

	localparam int data_width = pipe_pkg::DATA_WIDTH;
	localparam int addr_width = pipe_pkg::REG_ADDR_WIDTH;
	// Sections in order are reset reads, directed, opcodes, hold, gaps and random
	localparam int total_instr = 32 + 16 + 24 + 100 + 100 + 300;
	localparam int timeout_cycles = 4 * total_instr + 200;

	logic                  clk;
	logic                  arst_n;
	logic                  in_valid;
	pipe_pkg::alu_op_e     in_op;
	logic [addr_width-1:0] in_rd;
	logic [addr_width-1:0] in_ra;
	logic [addr_width-1:0] in_rb;
	logic [data_width-1:0] in_imm;
	logic                  in_use_imm;
	logic                  hold;
	logic                  in_ready;
	logic                  wb_valid;
	logic [addr_width-1:0] wb_rd;
	logic [data_width-1:0] wb_data;

	logic                  hold_random;
	int                    errors;
	int                    cycle_count;
	int                    drain_cycles;
	int                    idle_draw;
	// Architectural state and the results still in flight
	logic [data_width-1:0] arch_regs [1 << addr_width];
	logic [addr_width-1:0] exp_rd_q [$];
	logic [data_width-1:0] exp_data_q [$];
	logic [addr_width-1:0] exp_rd;
	logic [data_width-1:0] exp_data;
	logic [data_width-1:0] model_result;

	exec_pipe_top #(.data_width(data_width), .addr_width(addr_width)) exec_pipe_top_i (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_op(in_op), .in_rd(in_rd), .in_ra(in_ra), .in_rb(in_rb),
		.in_imm(in_imm), .in_use_imm(in_use_imm), .hold(hold), .in_ready(in_ready),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// One accepted instruction against the architectural registers
	// Register 0 is never written and keeps reading zero
	function automatic logic [data_width-1:0] reference_step(
		input pipe_pkg::alu_op_e     op,
		input logic [addr_width-1:0] rd,
		input logic [addr_width-1:0] ra,
		input logic [addr_width-1:0] rb,
		input logic [data_width-1:0] imm,
		input logic                  use_imm
	);
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic [data_width-1:0] result;
		a = arch_regs[ra];
		b = use_imm ? imm : arch_regs[rb];
		case (op)
			pipe_pkg::ALU_ADD: result = a + b;
			pipe_pkg::ALU_SUB: result = a - b;
			pipe_pkg::ALU_AND: result = a & b;
			pipe_pkg::ALU_OR:  result = a | b;
			pipe_pkg::ALU_XOR: result = a ^ b;
			// Shift distance wraps at the data width
			pipe_pkg::ALU_SLL: result = a << (b % data_width);
			pipe_pkg::ALU_SRL: result = a >> (b % data_width);
			default:           result = b;
		endcase
		if (rd != '0) begin
			arch_regs[rd] = result;
		end
		return result;
	endfunction

	// Values read at the accept edge are the ones the DUT samples
	always @(posedge clk) begin
		if (arst_n && in_valid && in_ready) begin
			model_result = reference_step(in_op, in_rd, in_ra, in_rb, in_imm, in_use_imm);
			if (in_rd != '0) begin
				exp_rd_q.push_back(in_rd);
				exp_data_q.push_back(model_result);
			end
		end
	end

	// Result retires at the next rising edge
	always @(negedge clk) begin
		if (arst_n && wb_valid && !hold) begin
			assert (exp_rd_q.size() != 0) else begin
				errors++;
				$display("Result for register %0d retired with none outstanding", wb_rd);
			end
			if (exp_rd_q.size() != 0) begin
				exp_rd = exp_rd_q.pop_front();
				exp_data = exp_data_q.pop_front();
				assert (wb_rd == exp_rd) else begin
					errors++;
					$display("Error wb_rd: got %h, expected %h", wb_rd, exp_rd);
				end
				assert (wb_data == exp_data) else begin
					errors++;
					$display("Error wb_data: got %h, expected %h", wb_data, exp_data);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// External stall on about one cycle in four while enabled
	always @(posedge clk) begin
		if (hold_random) begin
			hold <= ($urandom % 4) == 0;
		end else begin
			hold <= 1'b0;
		end
	end

	// Present one instruction and return on its accept edge
	task automatic issue(
		input pipe_pkg::alu_op_e     op,
		input logic [addr_width-1:0] rd,
		input logic [addr_width-1:0] ra,
		input logic [addr_width-1:0] rb,
		input logic [data_width-1:0] imm,
		input logic                  use_imm
	);
		in_valid   <= 1'b1;
		in_op      <= op;
		in_rd      <= rd;
		in_ra      <= ra;
		in_rb      <= rb;
		in_imm     <= imm;
		in_use_imm <= use_imm;
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic idle(input int cycles);
		in_valid <= 1'b0;
		repeat (cycles) @(posedge clk);
	endtask

	// Registers drawn below reg_span where small spans force hazards
	task automatic issue_random(input int reg_span);
		logic [31:0] r_op;
		logic [31:0] r_rd;
		logic [31:0] r_ra;
		logic [31:0] r_rb;
		logic [31:0] r_imm;
		logic [31:0] r_use;
		r_op = $urandom;
		r_rd = $urandom;
		r_ra = $urandom;
		r_rb = $urandom;
		r_imm = $urandom;
		r_use = $urandom;
		issue(pipe_pkg::alu_op_e'(r_op[2:0]), addr_width'(r_rd % reg_span),
			addr_width'(r_ra % reg_span), addr_width'(r_rb % reg_span), r_imm, r_use[0]);
	endtask

	initial begin
		void'($urandom(55403));
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_op = pipe_pkg::ALU_ADD;
		in_rd = '0;
		in_ra = '0;
		in_rb = '0;
		in_imm = '0;
		in_use_imm = 1'b0;
		hold = 1'b0;
		hold_random = 1'b0;
		errors = 0;
		for (int i = 0; i < (1 << addr_width); i++) begin
			arch_regs[i] = '0;
		end
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		// Idle pipe after reset
		@(negedge clk);
		assert (!wb_valid) else begin
			errors++;
			$display("Error wb_valid: got %h, expected %h", wb_valid, 1'b0);
		end
		assert (in_ready) else begin
			errors++;
			$display("Error in_ready: got %h, expected %h", in_ready, 1'b1);
		end
		@(posedge clk);
		// Each register is read before anything writes it
		for (int r = 31; r >= 0; r--) begin
			issue(pipe_pkg::ALU_PASS_B, addr_width'((r == 0) ? 1 : r), 5'd0,
				addr_width'(r), 32'h0, 1'b0);
		end

		// Execute forward followed by writeback forward
		issue(pipe_pkg::ALU_PASS_B, 5'd1, 5'd0, 5'd0, 32'h1234_5678, 1'b1);
		issue(pipe_pkg::ALU_ADD, 5'd2, 5'd1, 5'd1, 32'h0, 1'b0);
		issue(pipe_pkg::ALU_SUB, 5'd3, 5'd2, 5'd1, 32'h0, 1'b0);
		issue(pipe_pkg::ALU_PASS_B, 5'd4, 5'd0, 5'd0, 32'h0000_0f0f, 1'b1);
		issue(pipe_pkg::ALU_XOR, 5'd5, 5'd1, 5'd0, 32'h0000_ffff, 1'b1);
		issue(pipe_pkg::ALU_OR, 5'd6, 5'd4, 5'd5, 32'h0, 1'b0);
		issue(pipe_pkg::ALU_PASS_B, 5'd7, 5'd0, 5'd0, 32'ha5a5_0000, 1'b1);
		issue(pipe_pkg::ALU_AND, 5'd8, 5'd6, 5'd0, 32'hff00_ff00, 1'b1);
		issue(pipe_pkg::ALU_ADD, 5'd9, 5'd8, 5'd0, 32'h1, 1'b1);
		// Two instructions apart r7 comes from the register file
		issue(pipe_pkg::ALU_ADD, 5'd10, 5'd7, 5'd3, 32'h0, 1'b0);
		// The newer of two r12 producers in flight wins
		issue(pipe_pkg::ALU_PASS_B, 5'd12, 5'd0, 5'd0, 32'h1, 1'b1);
		issue(pipe_pkg::ALU_PASS_B, 5'd12, 5'd0, 5'd0, 32'h2, 1'b1);
		issue(pipe_pkg::ALU_ADD, 5'd13, 5'd12, 5'd12, 32'h0, 1'b0);
		// Producers across bubbles
		issue(pipe_pkg::ALU_SUB, 5'd14, 5'd13, 5'd0, 32'h5, 1'b1);
		idle(1);
		issue(pipe_pkg::ALU_XOR, 5'd15, 5'd14, 5'd10, 32'h0, 1'b0);
		idle(3);
		issue(pipe_pkg::ALU_OR, 5'd16, 5'd14, 5'd15, 32'h0, 1'b0);

		// All opcodes in immediate and register form with rd 0 never retiring
		for (int i = 0; i < 8; i++) begin
			issue(pipe_pkg::alu_op_e'(i[2:0]), addr_width'(16 + i), 5'd1, 5'd0,
				32'hf0f0_0003 + i, 1'b1);
			issue(pipe_pkg::alu_op_e'(i[2:0]), 5'd0, 5'd2, 5'd3, 32'h0, 1'b0);
			issue(pipe_pkg::alu_op_e'(i[2:0]), addr_width'(24 + i), 5'd3,
				addr_width'(16 + i), 32'h0, 1'b0);
		end

		hold_random <= 1'b1;
		repeat (100) issue_random(8);
		hold_random <= 1'b0;

		// Decode gaps with dense hazards
		repeat (100) begin
			issue_random(4);
			idle_draw = $urandom % 3;
			idle(idle_draw);
		end

		repeat (300) issue_random(32);

		// Drain and then allow a few cycles for stray results
		in_valid <= 1'b0;
		drain_cycles = 0;
		while (exp_rd_q.size() != 0 && drain_cycles < 50) begin
			@(negedge clk);
			drain_cycles++;
		end
		repeat (4) @(negedge clk);
		assert (exp_rd_q.size() == 0) else begin
			errors++;
			$display("%0d expected results never retired", exp_rd_q.size());
		end
		$display("Run ended with %0d errors", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		errors++;
		$display("Timeout after %0d cycles, the run did not complete", cycle_count);
		$display("Run ended with %0d errors", errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/forward_ctrl.sv
hdl/operand_muxes.sv
hdl/exec_stage.sv
hdl/exec_pipe_top.sv
tests/exec_pipe_properties.sv
tests/exec_pipe_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = exec_pipe_tb
FILE_LIST = tb.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Finished with no errors
SOURCES   = $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Pass only when the pass message shows up as a line of its own
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
